//--- hdl/aluPkg.sv
`default_nettype none

package aluPkg;

    localparam int DATA_W    = 32;                  // Operand and result width
    localparam int NUM_LANES = 4;                   // Identical ALU lanes
    localparam int LANE_W    = $clog2(NUM_LANES);   // Round-robin pointer width
    localparam int SHIFT_W   = $clog2(DATA_W);      // Variable shift amount bits
    localparam int OP_W      = 6;                   // MIPS function code width

    // MIPS function codes
    typedef enum logic [OP_W-1:0] {
        SLL  = 6'b000000,   // b << 1
        SRL  = 6'b000010,   // b >> 1
        SRA  = 6'b000011,   // a >>> 1
        SLLV = 6'b000100,   // b << a
        SRLV = 6'b000110,   // b >> a
        SRAV = 6'b000111,   // a >>> b
        MOVZ = 6'b001010,
        MOVN = 6'b001011,
        CLO  = 6'b011100,
        CLZ  = 6'b011101,
        ADD  = 6'b100000,
        ADDU = 6'b100001,
        SUB  = 6'b100010,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        NOR  = 6'b100111,
        SLT  = 6'b101010,
        SLTU = 6'b101011
    } aluOp_e;

    // Flag vector layout
    localparam int FLAG_W     = 5;
    localparam int FLAG_ZERO  = 0;  // Result all zero
    localparam int FLAG_NEG   = 1;  // Result bit 31
    localparam int FLAG_CARRY = 2;  // Carry out, or borrow on subtract
    localparam int FLAG_OVF   = 3;  // Signed overflow
    localparam int FLAG_COND  = 4;  // Conditional move taken

endpackage

`default_nettype wire

//--- hdl/aluBusPkg.sv
`default_nettype none

package aluBusPkg;

    localparam int ADDR_W = 8;

    // Register map, byte addresses
    localparam logic [ADDR_W-1:0] REG_OPA    = 8'h00;  // Operand a, write only
    localparam logic [ADDR_W-1:0] REG_OPB    = 8'h04;  // Operand b, write only
    localparam logic [ADDR_W-1:0] REG_CMD    = 8'h08;  // Opcode write issues
    localparam logic [ADDR_W-1:0] REG_RESULT = 8'h10;  // Head result, read pops
    localparam logic [ADDR_W-1:0] REG_FLAGS  = 8'h14;  // Head flags, no pop
    localparam logic [ADDR_W-1:0] REG_STATUS = 8'h18;  // Entry count

    // AXI response codes
    localparam int             RESP_W      = 2;
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

    // Result queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);  // Holds 0..QUEUE_DEPTH

endpackage

`default_nettype wire

//--- hdl/aluLane.sv
`timescale 1ns/1ps
`default_nettype none

module aluLane (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        issueValid,
    input  aluPkg::aluOp_e              issueOp,
    input  logic [aluPkg::DATA_W-1:0]   issueA,
    input  logic [aluPkg::DATA_W-1:0]   issueB,
    output logic                        laneValid,
    output logic [aluPkg::DATA_W-1:0]   laneResult,
    output logic [aluPkg::FLAG_W-1:0]   laneFlags
);
    import aluPkg::*;

    // Stage one operand capture
    logic              s1Valid;
    aluOp_e            s1Op;
    logic [DATA_W-1:0] s1A;
    logic [DATA_W-1:0] s1B;

    // Stage two combinational results
    logic [DATA_W-1:0] res;
    logic [DATA_W:0]   wide;    // Extra bit catches carry or borrow
    logic              carry;
    logic              ovf;
    logic              cond;
    logic [FLAG_W-1:0] flags;

    // Leading ones of x scanned from the top bit down
    function automatic logic [DATA_W-1:0] leadOnes(input logic [DATA_W-1:0] x);
        logic [DATA_W-1:0] n;
        logic              stop;
        n    = '0;
        stop = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--)
        begin
            if (!x[i])
                stop = 1'b1;
            else if (!stop)
                n = n + 1'b1;
        end
        return n;
    endfunction

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            s1Valid   <= 1'b0;
            laneValid <= 1'b0;
        end
        else
        begin
            s1Valid   <= issueValid;
            laneValid <= s1Valid;   // Fixed two-cycle latency
        end
    end

    always_ff @(posedge clk)
    begin
        if (issueValid)
        begin
            s1Op <= issueOp;
            s1A  <= issueA;
            s1B  <= issueB;
        end
        if (s1Valid)
        begin
            laneResult <= res;
            laneFlags  <= flags;
        end
    end

    always_comb
    begin
        res   = '0;
        wide  = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        cond  = 1'b0;
        case (s1Op)
            ADD, ADDU:
            begin
                wide  = {1'b0, s1A} + {1'b0, s1B};
                res   = wide[DATA_W-1:0];
                carry = (s1Op == ADDU) ? wide[DATA_W] : 1'b0;  // Unsigned form only
                // Same input signs but result sign flipped
                ovf   = (s1A[DATA_W-1] == s1B[DATA_W-1]) && (res[DATA_W-1] != s1A[DATA_W-1]);
            end
            SUB, SUBU:
            begin
                wide  = {1'b0, s1A} - {1'b0, s1B};
                res   = wide[DATA_W-1:0];
                carry = wide[DATA_W];   // Borrow when a < b unsigned
                ovf   = (s1A[DATA_W-1] != s1B[DATA_W-1]) && (res[DATA_W-1] != s1A[DATA_W-1]);
            end
            AND:  res = s1A & s1B;
            OR:   res = s1A | s1B;
            XOR:  res = s1A ^ s1B;
            NOR:  res = ~(s1A | s1B);
            SLT:  res = DATA_W'($signed(s1A) < $signed(s1B));
            SLTU: res = DATA_W'(s1A < s1B);
            // Data and amount operands differ per shift opcode
            SLL:  res = s1B << 1;
            SRL:  res = s1B >> 1;
            SRA:  res = $signed(s1A) >>> 1;
            SLLV: res = s1B << s1A[SHIFT_W-1:0];
            SRLV: res = s1B >> s1A[SHIFT_W-1:0];
            SRAV: res = $signed(s1A) >>> s1B[SHIFT_W-1:0];
            CLO:  res = leadOnes(s1A);
            CLZ:  res = leadOnes(~s1A);   // Zeros of a are ones of ~a
            MOVZ:
            begin
                cond = (s1B == '0);
                res  = cond ? s1A : '0;
            end
            MOVN:
            begin
                cond = (s1B != '0);
                res  = cond ? s1A : '0;
            end
            default: res = '0;
        endcase

        flags             = '0;
        flags[FLAG_ZERO]  = (res == '0);
        flags[FLAG_NEG]   = res[DATA_W-1];
        flags[FLAG_CARRY] = carry;
        flags[FLAG_OVF]   = ovf;
        flags[FLAG_COND]  = cond;
    end

endmodule

`default_nettype wire

//--- hdl/aluDispatch.sv
`timescale 1ns/1ps
`default_nettype none

module aluDispatch (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [aluBusPkg::ADDR_W-1:0]    awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [aluPkg::DATA_W-1:0]       wdata,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [aluBusPkg::RESP_W-1:0]    bresp,
    input  logic                            full,
    output logic [aluPkg::NUM_LANES-1:0]    issueValid,
    output aluPkg::aluOp_e                  issueOp,
    output logic [aluPkg::DATA_W-1:0]       issueA,
    output logic [aluPkg::DATA_W-1:0]       issueB
);
    import aluPkg::*;
    import aluBusPkg::*;

    logic [LANE_W-1:0] lanePtr;     // Next lane to issue to
    aluOp_e            newOp;
    logic              isCmd;
    logic              cmdLegal;
    logic              writeOk;
    logic              accept;      // AW and W handshake together

    assign newOp = aluOp_e'(wdata[OP_W-1:0]);
    assign isCmd = (awaddr == REG_CMD);

    // Opcode must be one of the enum codes
    always_comb
    begin
        case (newOp)
            ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
            SLL, SRL, SRA, SLLV, SRLV, SRAV, CLZ, CLO, MOVZ, MOVN:
                cmdLegal = 1'b1;
            default:
                cmdLegal = 1'b0;
        endcase
    end

    assign writeOk = (awaddr == REG_OPA) || (awaddr == REG_OPB) || (isCmd && cmdLegal);

    // Command writes stall while the result queue cannot take another entry
    assign accept  = awvalid && wvalid && (!bvalid || bready) && !(isCmd && full);
    assign awready = accept;
    assign wready  = accept;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            bvalid     <= 1'b0;
            issueValid <= '0;
            lanePtr    <= '0;
        end
        else
        begin
            issueValid <= '0;   // One-cycle pulse per issue
            if (accept)
            begin
                bvalid <= 1'b1;
                if (isCmd && cmdLegal)
                begin
                    issueValid <= NUM_LANES'(1) << lanePtr;
                    lanePtr    <= (lanePtr == LANE_W'(NUM_LANES - 1)) ? '0 : lanePtr + 1'b1;
                end
            end
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    // Operands and response payload
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            bresp <= writeOk ? RESP_OKAY : RESP_SLVERR;
            if (awaddr == REG_OPA)
                issueA <= wdata;
            if (awaddr == REG_OPB)
                issueB <= wdata;
            if (isCmd && cmdLegal)
                issueOp <= newOp;
        end
    end

endmodule

`default_nettype wire

//--- hdl/aluCollect.sv
`timescale 1ns/1ps
`default_nettype none

module aluCollect (
    input  logic                                                clk,
    input  logic                                                rstN,
    input  logic [aluPkg::NUM_LANES-1:0]                        issueValid,
    input  logic [aluPkg::NUM_LANES-1:0]                        laneValid,
    input  logic [aluPkg::NUM_LANES-1:0][aluPkg::DATA_W-1:0]    laneResult,
    input  logic [aluPkg::NUM_LANES-1:0][aluPkg::FLAG_W-1:0]    laneFlags,
    input  logic                                                arvalid,
    output logic                                                arready,
    input  logic [aluBusPkg::ADDR_W-1:0]                        araddr,
    output logic                                                rvalid,
    input  logic                                                rready,
    output logic [aluPkg::DATA_W-1:0]                           rdata,
    output logic [aluBusPkg::RESP_W-1:0]                        rresp,
    output logic                                                full
);
    import aluPkg::*;
    import aluBusPkg::*;

    logic [LANE_W-1:0] lanePtr;             // Lane expected to finish next
    logic [DATA_W-1:0] resultMem [QUEUE_DEPTH];
    logic [FLAG_W-1:0] flagsMem  [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wrPtr;
    logic [QPTR_W-1:0] rdPtr;
    logic [QCNT_W-1:0] count;               // Stored entries
    logic [QCNT_W-1:0] inFlight;            // Issued, not yet pushed
    logic [QCNT_W:0]   occupancy;
    logic              push;
    logic              pop;
    logic              arFire;
    logic              notEmpty;
    logic [DATA_W-1:0] rdNext;
    logic [RESP_W-1:0] respNext;

    assign push     = laneValid[lanePtr];  // Lanes finish in issue order
    assign arFire   = arvalid && arready;
    assign notEmpty = (count != '0);
    assign pop      = arFire && (araddr == REG_RESULT) && notEmpty;

    // Count a fresh issue pulse at once so back-to-back commands see it
    assign occupancy = {1'b0, count} + {1'b0, inFlight} + {{QCNT_W{1'b0}}, |issueValid};
    assign full      = (occupancy >= QUEUE_DEPTH);

    // Read decode
    always_comb
    begin
        rdNext   = '0;
        respNext = RESP_OKAY;
        case (araddr)
            REG_RESULT:
                if (notEmpty)
                    rdNext = resultMem[rdPtr];
                else
                    respNext = RESP_SLVERR;     // Empty queue reads zero
            REG_FLAGS:
                if (notEmpty)
                    rdNext = DATA_W'(flagsMem[rdPtr]);
                else
                    respNext = RESP_SLVERR;
            REG_STATUS: rdNext = DATA_W'(count);
            default:    respNext = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            lanePtr  <= '0;
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            inFlight <= '0;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                lanePtr <= (lanePtr == LANE_W'(NUM_LANES - 1)) ? '0 : lanePtr + 1'b1;
                wrPtr   <= (wrPtr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop)
                rdPtr <= (rdPtr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase

            case ({|issueValid, push})
                2'b10:   inFlight <= inFlight + 1'b1;
                2'b01:   inFlight <= inFlight - 1'b1;
                default: inFlight <= inFlight;
            endcase

            // One read outstanding at a time
            if (arFire)
            begin
                rvalid  <= 1'b1;
                arready <= 1'b0;
            end
            else if (rvalid && rready)
            begin
                rvalid  <= 1'b0;
                arready <= 1'b1;
            end
            else if (!rvalid)
                arready <= 1'b1;    // Comes up the cycle after reset
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            resultMem[wrPtr] <= laneResult[lanePtr];
            flagsMem[wrPtr]  <= laneFlags[lanePtr];
        end
        if (arFire)
        begin
            rdata <= rdNext;
            rresp <= respNext;
        end
    end

endmodule

`default_nettype wire

//--- hdl/aluCluster.sv
`timescale 1ns/1ps
`default_nettype none

module aluCluster (
    input  logic                            clk,
    input  logic                            rstN,
    // Write channels
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [aluBusPkg::ADDR_W-1:0]    awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [aluPkg::DATA_W-1:0]       wdata,
    output logic                            bvalid,
    input  logic                            bready,
    output logic [aluBusPkg::RESP_W-1:0]    bresp,
    // Read channels
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [aluBusPkg::ADDR_W-1:0]    araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [aluPkg::DATA_W-1:0]       rdata,
    output logic [aluBusPkg::RESP_W-1:0]    rresp
);
    import aluPkg::*;

    logic [NUM_LANES-1:0]             issueValid;  // One-hot lane select
    aluOp_e                           issueOp;
    logic [DATA_W-1:0]                issueA;
    logic [DATA_W-1:0]                issueB;
    logic [NUM_LANES-1:0]             laneValid;
    logic [NUM_LANES-1:0][DATA_W-1:0] laneResult;
    logic [NUM_LANES-1:0][FLAG_W-1:0] laneFlags;
    logic                             full;        // Queue back-pressure

    aluDispatch dispatch_i (
        .clk        (clk),
        .rstN       (rstN),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .full       (full),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueA     (issueA),
        .issueB     (issueB)
    );

    // All lanes see the same operands, only the addressed one takes them
    for (genvar g = 0; g < NUM_LANES; g++)
    begin : genLane
        aluLane lane_i (
            .clk        (clk),
            .rstN       (rstN),
            .issueValid (issueValid[g]),
            .issueOp    (issueOp),
            .issueA     (issueA),
            .issueB     (issueB),
            .laneValid  (laneValid[g]),
            .laneResult (laneResult[g]),
            .laneFlags  (laneFlags[g])
        );
    end

    aluCollect collect_i (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),   // Feeds the in-flight count
        .laneValid  (laneValid),
        .laneResult (laneResult),
        .laneFlags  (laneFlags),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .full       (full)
    );

endmodule

`default_nettype wire

//--- test/aluCluster_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module aluCluster_assertions (
    input logic                            clk,
    input logic                            rstN,
    input logic                            awready,
    input logic [aluBusPkg::ADDR_W-1:0]    awaddr,
    input logic                            wready,
    input logic                            bvalid,
    input logic                            bready,
    input logic [aluBusPkg::RESP_W-1:0]    bresp,
    input logic                            arready,
    input logic                            rvalid,
    input logic                            rready,
    input logic [aluPkg::DATA_W-1:0]       rdata,
    input logic [aluBusPkg::RESP_W-1:0]    rresp,
    input logic                            full
);
    import aluBusPkg::*;

    int failCount = 0;  // Failed checks so far

    // Write response stays put until bready
    bHoldChk: assert property (@(posedge clk) disable iff (!rstN)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else
    begin
        failCount++;
        $error("bvalid or bresp changed before bready");
    end

    // Read data stays put until rready
    rHoldChk: assert property (@(posedge clk) disable iff (!rstN)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else
    begin
        failCount++;
        $error("rvalid, rdata or rresp changed before rready");
    end

    // Quiet bus while in reset
    resetChk: assert property (@(posedge clk)
        !rstN |-> !awready && !wready && !bvalid && !arready && !rvalid)
    else
    begin
        failCount++;
        $error("Handshake or response signal high during reset");
    end

    // No command accepted into a full queue
    fullChk: assert property (@(posedge clk) disable iff (!rstN)
        awready && (awaddr == REG_CMD) |-> !full)
    else
    begin
        failCount++;
        $error("Command write accepted while full");
    end

endmodule

bind aluCluster aluCluster_assertions assertions_i (
    .clk     (clk),
    .rstN    (rstN),
    .awready (awready),
    .awaddr  (awaddr),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .full    (full)
);

`default_nettype wire

//--- test/aluClusterTb.sv
`timescale 1ns/1ps
`default_nettype none

module aluClusterTb;
    import aluPkg::*;
    import aluBusPkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int NUM_OPS     = 140;                          // All issued commands rounded up
    localparam int WATCHDOG_NS = NUM_OPS * 40 * CLK_PERIOD + 2000;

    logic                clk;
    logic                rstN;
    logic                awvalid;
    logic                awready;
    logic [ADDR_W-1:0]   awaddr;
    logic                wvalid;
    logic                wready;
    logic [DATA_W-1:0]   wdata;
    logic                bvalid;
    logic                bready;
    logic [RESP_W-1:0]   bresp;
    logic                arvalid;
    logic                arready;
    logic [ADDR_W-1:0]   araddr;
    logic                rvalid;
    logic                rready;
    logic [DATA_W-1:0]   rdata;
    logic [RESP_W-1:0]   rresp;

    logic [DATA_W-1:0]   seed = 32'h19cc6d26;
    logic [DATA_W-1:0]   opA;
    logic [DATA_W-1:0]   opB;
    int                  bHold = 0;     // Cycles bready stays low
    int                  rHold = 0;     // Cycles rready stays low
    logic [DATA_W-1:0]   expResults [$];
    logic [FLAG_W-1:0]   expFlags [$];

    logic [DATA_W-1:0]   cornerA [4] = '{32'h7fffffff, 32'h80000000, 32'hffffffff, 32'h0};
    logic [DATA_W-1:0]   cornerB [4] = '{32'h00000001, 32'hffffffff, 32'h00000001, 32'h1};
    aluOp_e              bitOps [10] = '{AND, OR, XOR, NOR, SLL, SRL, SRA, SLLV, SRLV, SRAV};
    aluOp_e              burstOps [5] = '{ADD, SUB, XOR, SLT, NOR};

    aluCluster aluCluster_i (
        .clk     (clk),
        .rstN    (rstN),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [DATA_W-1:0] randWord();
        seed = seed * 32'd1664525 + 32'd1013904223;    // Numerical Recipes constants
        return seed;
    endfunction

    // Expected result and flags straight from the opcode rules
    function automatic logic [DATA_W-1:0] modelOp(input aluOp_e op, input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b,
                                                  output logic [FLAG_W-1:0] flags);
        longint            sa;
        longint            sb;
        longint            exact;   // Signed answer at full precision
        logic [DATA_W-1:0] r;
        logic              carry;
        logic              ovf;
        logic              cond;
        int                n;
        sa    = $signed(a);
        sb    = $signed(b);
        exact = 0;
        r     = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        cond  = 1'b0;
        n     = 0;
        case (op)
            ADD, ADDU:
            begin
                r     = a + b;
                exact = sa + sb;
                ovf   = (exact != longint'($signed(r)));   // Does not fit in 32 signed bits
                carry = (op == ADDU) && ((longint'(a) + longint'(b)) > longint'(32'hffffffff));
            end
            SUB, SUBU:
            begin
                r     = a - b;
                exact = sa - sb;
                ovf   = (exact != longint'($signed(r)));
                carry = (a < b);    // Borrow
            end
            AND:  r = a & b;
            OR:   r = a | b;
            XOR:  r = a ^ b;
            NOR:  r = ~(a | b);
            SLT:  r = (sa < sb) ? 1 : 0;
            SLTU: r = (a < b) ? 1 : 0;
            SLL:  r = b << 1;
            SRL:  r = b >> 1;
            SRA:  r = DATA_W'(sa >>> 1);
            SLLV: r = b << a[SHIFT_W-1:0];
            SRLV: r = b >> a[SHIFT_W-1:0];
            SRAV: r = DATA_W'(sa >>> b[SHIFT_W-1:0]);
            CLZ:
            begin
                while (n < DATA_W && !a[DATA_W-1-n])
                    n++;
                r = n;
            end
            CLO:
            begin
                while (n < DATA_W && a[DATA_W-1-n])
                    n++;
                r = n;
            end
            MOVZ:
            begin
                cond = (b == 0);
                r    = cond ? a : '0;
            end
            MOVN:
            begin
                cond = (b != 0);
                r    = cond ? a : '0;
            end
            default: r = '0;
        endcase
        flags             = '0;
        flags[FLAG_ZERO]  = (r == 0);
        flags[FLAG_NEG]   = r[DATA_W-1];
        flags[FLAG_CARRY] = carry;
        flags[FLAG_OVF]   = ovf;
        flags[FLAG_COND]  = cond;
        return r;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic busWrite(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output logic [RESP_W-1:0] resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (bHold == 0);
        @(posedge clk);
        while (!(awready && wready))
            @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid)
        begin
            @(posedge clk);
            #1;
        end
        resp = bresp;
        if (bHold > 0)
        begin
            repeat (bHold) @(posedge clk);
            #1;
            bready = 1'b1;
            @(posedge clk);     // B handshake
            #1;
        end
    endtask

    task automatic busRead(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic [RESP_W-1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (rHold == 0);
        @(posedge clk);
        while (!arready)
            @(posedge clk);
        #1;
        arvalid = 1'b0;
        while (!rvalid)
        begin
            @(posedge clk);
            #1;
        end
        data = rdata;
        resp = rresp;
        if (rHold > 0)
        begin
            repeat (rHold) @(posedge clk);
            #1;
            rready = 1'b1;
        end
        @(posedge clk);         // R handshake
        #1;
    endtask

    task automatic writeExpect(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic [RESP_W-1:0] expResp);
        logic [RESP_W-1:0] resp;
        busWrite(addr, data, resp);
        assert (resp == expResp)
        else
            failRun($sformatf("[ERROR] bresp addr %h expected %h got %h", addr, expResp, resp));
    endtask

    task automatic readExpect(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expData,
                              input logic [RESP_W-1:0] expResp);
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
        busRead(addr, data, resp);
        assert (resp == expResp)
        else
            failRun($sformatf("[ERROR] rresp addr %h expected %h got %h", addr, expResp, resp));
        assert (data == expData)
        else
            failRun($sformatf("[ERROR] rdata addr %h expected %h got %h", addr, expData, data));
    endtask

    task automatic pushExpect(input aluOp_e op, input logic [DATA_W-1:0] a,
                              input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] r;
        logic [FLAG_W-1:0] f;
        r = modelOp(op, a, b, f);
        expResults.push_back(r);
        expFlags.push_back(f);
    endtask

    // Poll the entry count
    task automatic waitEntries(input int n);
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
        int                polls;
        polls = 0;
        busRead(REG_STATUS, data, resp);
        while (data < n)
        begin
            polls++;
            if (polls > 20)
                failRun("Result queue never reached the expected entry count");
            busRead(REG_STATUS, data, resp);
        end
    endtask

    task automatic checkHead();
        readExpect(REG_FLAGS, DATA_W'(expFlags.pop_front()), RESP_OKAY);   // No pop
        readExpect(REG_RESULT, expResults.pop_front(), RESP_OKAY);
    endtask

    task automatic drainResults(input int n);
        for (int i = 0; i < n; i++)
        begin
            waitEntries(1);
            checkHead();
        end
    endtask

    task automatic runOp(input aluOp_e op, input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        writeExpect(REG_OPA, a, RESP_OKAY);
        writeExpect(REG_OPB, b, RESP_OKAY);
        writeExpect(REG_CMD, DATA_W'(op), RESP_OKAY);
        pushExpect(op, a, b);
        drainResults(1);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        failRun("Timeout, the run did not finish in the expected time");
    end

    initial
    begin
        clk     = 1'b0;
        rstN    = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;

        // Add and subtract with corner operands first
        for (int i = 0; i < 10; i++)
        begin
            opA = (i < 4) ? cornerA[i] : randWord();
            opB = (i < 4) ? cornerB[i] : randWord();
            runOp(ADD, opA, opB);
            runOp(ADDU, opA, opB);
            runOp(SUB, opA, opB);
            runOp(SUBU, opA, opB);
        end

        // Logic and shifts with one slow bready and rready pass
        for (int i = 0; i < 6; i++)
        begin
            opA   = (i == 0) ? 32'h80000001 : randWord();
            opB   = (i == 0) ? 32'h80000001 : randWord();   // XOR gives zero
            bHold = (i == 1) ? 2 : 0;
            rHold = (i == 1) ? 3 : 0;
            foreach (bitOps[k])
                runOp(bitOps[k], opA, opB);
        end
        bHold = 0;
        rHold = 0;

        // Compares and counts
        for (int i = 0; i < 7; i++)
        begin
            opA = (i == 0 || i == 2) ? 32'h0 : (i == 1) ? 32'hffffffff : randWord();
            opB = (i == 0) ? 32'h0 : (i < 3) ? 32'hffffffff : randWord();
            runOp(SLT, opA, opB);
            runOp(SLTU, opA, opB);
            runOp(CLZ, opA, opB);
            runOp(CLO, opA, opB);
        end

        // Conditional moves taken and not taken
        opA = randWord();
        opB = randWord() | 32'h1;
        runOp(MOVZ, opA, 32'h0);
        runOp(MOVZ, opA, opB);
        runOp(MOVN, opA, 32'h0);
        runOp(MOVN, opA, opB);

        // Back-to-back issues fill the queue so the fifth command stalls
        opA = 32'h000000ff;     // Every burst op gives a distinct result
        opB = 32'h00000f0f;
        writeExpect(REG_OPA, opA, RESP_OKAY);
        writeExpect(REG_OPB, opB, RESP_OKAY);
        for (int i = 0; i < QUEUE_DEPTH; i++)
        begin
            writeExpect(REG_CMD, DATA_W'(burstOps[i]), RESP_OKAY);
            pushExpect(burstOps[i], opA, opB);
        end
        pushExpect(burstOps[4], opA, opB);
        fork
            writeExpect(REG_CMD, DATA_W'(burstOps[4]), RESP_OKAY);
            begin
                repeat (6)
                begin
                    @(posedge clk);
                    assert (!awready && !wready)
                    else
                        failRun("Command write was accepted while the result queue was full");
                end
                #1;
                readExpect(REG_STATUS, QUEUE_DEPTH, RESP_OKAY);
                checkHead();    // Pop frees a slot
            end
        join
        drainResults(QUEUE_DEPTH);

        // Error responses
        writeExpect(REG_CMD, 32'h0000003f, RESP_SLVERR);   // Not a function code
        writeExpect(8'h40, 32'h12345678, RESP_SLVERR);
        readExpect(8'h40, '0, RESP_SLVERR);
        readExpect(REG_RESULT, '0, RESP_SLVERR);
        readExpect(REG_STATUS, '0, RESP_OKAY);

        repeat (2) @(posedge clk);
        if (aluCluster_i.assertions_i.failCount == 0)
        begin
            $display("test passed");
            $finish;
        end
        else
            failRun("Bound protocol assertions reported failures");
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/aluPkg.sv
hdl/aluBusPkg.sv
hdl/aluLane.sv
hdl/aluDispatch.sv
hdl/aluCollect.sv
hdl/aluCluster.sv
test/aluCluster_assertions.sv
test/aluClusterTb.sv
